/* include/marin_params.svh */
// Address map and timing constants for the peripheral subsystem.
// All bases are byte addresses and every base is aligned to its region size.
// The watchdog limit must be at least 2.
`ifndef MARIN_PARAMS_SVH
`define MARIN_PARAMS_SVH

// Word RAM at byte address 0, 512 words, 1 KB region
`define MARIN_RAM_BASE 32'h0000_0000
`define MARIN_RAM_ADDR_BITS 9

// Each register slave owns a 4-byte slot
`define MARIN_REG_ADDR_BITS 2

// Hex display, interrupt controller and watchdog status
`define MARIN_DISP_BASE 32'hF000_0000
`define MARIN_PIC_BASE 32'hF000_0010
`define MARIN_WDT_BASE 32'hF000_0020

// Timer tick period in clocks
`define MARIN_TICK_PERIOD 100

// Strobe cycles without ack before the watchdog ends the cycle
`define MARIN_WDT_LIMIT 16

`endif

/* logic/wb_pkg.sv */
// Bus types for the 16-bit Wishbone-style peripheral bus.
// Cyc and stb are merged into a single strobe since no slave
// distinguishes them.
package wb_pkg;

  // Byte address from the master
  typedef logic [31:0] wb_addr_t;

  // One bus data word
  typedef logic [15:0] wb_data_t;

  // Byte-lane select, bit 0 is the low byte
  typedef logic [1:0] wb_sel_t;

  // Master to slave
  typedef struct packed {
    wb_addr_t adr;
    wb_data_t dat;
    wb_sel_t  sel;
    logic     we;
    logic     stb;
  } wb_req_t;

  // Slave to master, dat is valid while ack is high
  typedef struct packed {
    wb_data_t dat;
    logic     ack;
  } wb_rsp_t;

endpackage

/* logic/periph_pkg.sv */
// Types shared by the peripherals.
// Segment patterns are active low with bit 0 driving segment a.
package periph_pkg;

  // Bits 3..0 are the buttons, bit 4 is the timer tick
  typedef logic [4:0] irq_vec_t;

  // One display digit
  typedef logic [3:0] hex_digit_t;

  // Segments g..a, active low
  typedef logic [6:0] seg7_t;

  // Bus watchdog FSM
  typedef enum logic [1:0] {
    WDT_IDLE,
    WDT_WAIT,
    WDT_FAULT
  } wdt_state_e;

  // Saturating count of terminated cycles
  typedef logic [7:0] wdt_count_t;

endpackage

/* logic/wb_intercon.sv */
// Address decoder and response mux for one master and four slaves.
// Purely combinational. An unmapped address strobes no slave and is
// ended only by the watchdog terminate, which returns zero data.
`include "marin_params.svh"

module wb_intercon (
  input  wb_pkg::wb_req_t wbm_req_i,
  output wb_pkg::wb_rsp_t wbm_rsp_o,
  input  logic            wdt_term_i,

  output wb_pkg::wb_req_t ram_req_o,
  output wb_pkg::wb_req_t disp_req_o,
  output wb_pkg::wb_req_t pic_req_o,
  output wb_pkg::wb_req_t wdt_req_o,

  input  wb_pkg::wb_rsp_t ram_rsp_i,
  input  wb_pkg::wb_rsp_t disp_rsp_i,
  input  wb_pkg::wb_rsp_t pic_rsp_i,
  input  wb_pkg::wb_rsp_t wdt_rsp_i
);

  // Lowest address bit that is compared for each region
  localparam int RAM_LSB = `MARIN_RAM_ADDR_BITS + 1;
  localparam int REG_LSB = `MARIN_REG_ADDR_BITS;

  localparam wb_pkg::wb_addr_t RAM_BASE  = `MARIN_RAM_BASE;
  localparam wb_pkg::wb_addr_t DISP_BASE = `MARIN_DISP_BASE;
  localparam wb_pkg::wb_addr_t PIC_BASE  = `MARIN_PIC_BASE;
  localparam wb_pkg::wb_addr_t WDT_BASE  = `MARIN_WDT_BASE;

  logic ram_hit;
  logic disp_hit;
  logic pic_hit;
  logic wdt_hit;

  assign ram_hit  = (wbm_req_i.adr[31:RAM_LSB] == RAM_BASE[31:RAM_LSB]);
  assign disp_hit = (wbm_req_i.adr[31:REG_LSB] == DISP_BASE[31:REG_LSB]);
  assign pic_hit  = (wbm_req_i.adr[31:REG_LSB] == PIC_BASE[31:REG_LSB]);
  assign wdt_hit  = (wbm_req_i.adr[31:REG_LSB] == WDT_BASE[31:REG_LSB]);

  // Every slave sees the request, only the addressed one gets the strobe
  always_comb begin
    ram_req_o      = wbm_req_i;
    disp_req_o     = wbm_req_i;
    pic_req_o      = wbm_req_i;
    wdt_req_o      = wbm_req_i;
    ram_req_o.stb  = wbm_req_i.stb & ram_hit;
    disp_req_o.stb = wbm_req_i.stb & disp_hit;
    pic_req_o.stb  = wbm_req_i.stb & pic_hit;
    wdt_req_o.stb  = wbm_req_i.stb & wdt_hit;
  end

  always_comb begin
    wbm_rsp_o.ack = ram_rsp_i.ack | disp_rsp_i.ack | pic_rsp_i.ack |
                    wdt_rsp_i.ack | wdt_term_i;

    // Terminated cycles read as zero
    if (wdt_term_i) begin
      wbm_rsp_o.dat = '0;
    end else if (ram_hit) begin
      wbm_rsp_o.dat = ram_rsp_i.dat;
    end else if (disp_hit) begin
      wbm_rsp_o.dat = disp_rsp_i.dat;
    end else if (pic_hit) begin
      wbm_rsp_o.dat = pic_rsp_i.dat;
    end else if (wdt_hit) begin
      wbm_rsp_o.dat = wdt_rsp_i.dat;
    end else begin
      wbm_rsp_o.dat = '0;
    end
  end

endmodule

/* logic/wb_watchdog.sv */
// Ends bus cycles that no slave answers and reports them.
// Status word: bit 15 sticky fault, bits 7..0 saturating fault count.
// Any write to the status slot clears both.
`include "marin_params.svh"

module wb_watchdog (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            mstb_i,
  input  logic            mack_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o,
  output logic            term_o
);

  localparam int LIMIT = `MARIN_WDT_LIMIT;
  localparam int CNT_W = $clog2(LIMIT + 1);

  periph_pkg::wdt_state_e state_q;
  periph_pkg::wdt_state_e state_d;
  logic [CNT_W-1:0]       wait_cnt_q;
  logic                   fault_q;
  periph_pkg::wdt_count_t fault_cnt_q;
  logic                   ack_q;
  wb_pkg::wb_data_t       dat_q;
  logic                   reg_access;

  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_pkg::WDT_IDLE: begin
        if (mstb_i) begin
          state_d = periph_pkg::WDT_WAIT;
        end
      end
      periph_pkg::WDT_WAIT: begin
        if (!mstb_i || mack_i) begin
          state_d = periph_pkg::WDT_IDLE;
        end else if (wait_cnt_q == CNT_W'(LIMIT - 1)) begin
          state_d = periph_pkg::WDT_FAULT;
        end
      end
      default: state_d = periph_pkg::WDT_IDLE;
    endcase
  end

  // The cycle seen in idle already counts as the first one
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= periph_pkg::WDT_IDLE;
      wait_cnt_q <= CNT_W'(1);
    end else begin
      state_q <= state_d;
      if (state_q == periph_pkg::WDT_WAIT) begin
        wait_cnt_q <= wait_cnt_q + CNT_W'(1);
      end else begin
        wait_cnt_q <= CNT_W'(1);
      end
    end
  end

  assign term_o     = (state_q == periph_pkg::WDT_FAULT);
  assign reg_access = req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      fault_q     <= 1'b0;
      fault_cnt_q <= '0;
    end else begin
      ack_q <= reg_access;
      if (reg_access && req_i.we) begin
        fault_q     <= 1'b0;
        fault_cnt_q <= '0;
      end else if (term_o) begin
        fault_q <= 1'b1;
        if (fault_cnt_q != '1) begin
          fault_cnt_q <= fault_cnt_q + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_access) begin
      dat_q <= {fault_q, 7'b0, fault_cnt_q};
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

endmodule

/* logic/mtimer.sv */
// Periodic tick generator.
// The first one-cycle pulse comes TICK_PERIOD clocks after reset release.
// TICK_PERIOD must be at least 2.
`include "marin_params.svh"

module mtimer #(
  parameter int TICK_PERIOD = `MARIN_TICK_PERIOD
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic tick_o
);

  localparam int CNT_W = $clog2(TICK_PERIOD + 1);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= RELOAD;
      tick_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= RELOAD;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - CNT_W'(1);
      tick_o <= 1'b0;
    end
  end

endmodule

/* logic/mpic_wb.sv */
// Interrupt controller for five edge-triggered lines.
// Offset 0 reads pending, write 1 to clear. Offset 2 is the enable mask.
// Input lines are expected to be synchronous to clk_i.
module mpic_wb (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  wb_pkg::wb_req_t      req_i,
  output wb_pkg::wb_rsp_t      rsp_o,
  input  periph_pkg::irq_vec_t irq_i,
  output logic                 irq_o
);

  periph_pkg::irq_vec_t irq_prev_q;
  periph_pkg::irq_vec_t pending_q;
  periph_pkg::irq_vec_t enable_q;
  periph_pkg::irq_vec_t rise;
  periph_pkg::irq_vec_t clr;
  logic                 ack_q;
  wb_pkg::wb_data_t     dat_q;
  logic                 access;
  logic                 wr_low;

  assign access = req_i.stb & ~ack_q;
  // All register bits live in the low byte lane
  assign wr_low = access & req_i.we & req_i.sel[0];
  assign rise   = irq_i & ~irq_prev_q;
  assign clr    = (wr_low && !req_i.adr[1]) ? req_i.dat[4:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_prev_q <= '0;
      pending_q  <= '0;
      enable_q   <= '0;
      ack_q      <= 1'b0;
    end else begin
      irq_prev_q <= irq_i;
      ack_q      <= access;
      // A new edge wins over a clear in the same cycle
      pending_q  <= (pending_q & ~clr) | rise;
      if (wr_low && req_i.adr[1]) begin
        enable_q <= req_i.dat[4:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= {11'b0, req_i.adr[1] ? enable_q : pending_q};
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;
  assign irq_o     = |(pending_q & enable_q);

endmodule

/* logic/ram16_wb.sv */
// Single-port word RAM, 2**MARIN_RAM_ADDR_BITS words of 16 bits.
// Contents are undefined after power-up. Reset clears only the ack.
`include "marin_params.svh"

module ram16_wb (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  localparam int AW    = `MARIN_RAM_ADDR_BITS;
  localparam int WORDS = 1 << AW;

  wb_pkg::wb_data_t mem [WORDS];
  wb_pkg::wb_data_t dat_q;
  logic [AW-1:0]    idx;
  logic             ack_q;
  logic             access;

  // Byte address bit 0 selects the lane, not the word
  assign idx    = req_i.adr[AW:1];
  assign access = req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      if (req_i.sel[0]) begin
        mem[idx][7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        mem[idx][15:8] <= req_i.dat[15:8];
      end
    end
    dat_q <= mem[idx];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

endmodule

/* logic/hex_display_wb.sv */
// Four-digit seven-segment display register.
// Outputs are active low and stay blank until the first write.
// hex0 shows the lowest nibble.
module hex_display_wb (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  wb_pkg::wb_req_t   req_i,
  output wb_pkg::wb_rsp_t   rsp_o,
  output periph_pkg::seg7_t hex0_o,
  output periph_pkg::seg7_t hex1_o,
  output periph_pkg::seg7_t hex2_o,
  output periph_pkg::seg7_t hex3_o
);

  wb_pkg::wb_data_t value_q;
  logic             valid_q;
  logic             ack_q;
  logic             access;

  // Segment order g..a, a is bit 0
  function automatic periph_pkg::seg7_t hex_to_seg(periph_pkg::hex_digit_t d);
    case (d)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  assign access = req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && req_i.we) begin
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      if (req_i.sel[0]) begin
        value_q[7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        value_q[15:8] <= req_i.dat[15:8];
      end
    end
  end

  assign rsp_o.dat = value_q;
  assign rsp_o.ack = ack_q;

  assign hex0_o = valid_q ? hex_to_seg(value_q[3:0])   : '1;
  assign hex1_o = valid_q ? hex_to_seg(value_q[7:4])   : '1;
  assign hex2_o = valid_q ? hex_to_seg(value_q[11:8])  : '1;
  assign hex3_o = valid_q ? hex_to_seg(value_q[15:12]) : '1;

endmodule

/* logic/marin_periph.sv */
// Peripheral subsystem: decoder, RAM, display, interrupt controller,
// tick timer and bus watchdog behind one bus master port.
// The master must hold its request until ack and then drop the strobe.
`include "marin_params.svh"

module marin_periph #(
  parameter int TICK_PERIOD = `MARIN_TICK_PERIOD
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  wb_pkg::wb_req_t   wbm_req_i,
  output wb_pkg::wb_rsp_t   wbm_rsp_o,
  input  logic [3:0]        btn_i,
  output logic              irq_o,
  output logic              buserr_o,
  output periph_pkg::seg7_t hex0_o,
  output periph_pkg::seg7_t hex1_o,
  output periph_pkg::seg7_t hex2_o,
  output periph_pkg::seg7_t hex3_o
);

  wb_pkg::wb_req_t ram_req;
  wb_pkg::wb_req_t disp_req;
  wb_pkg::wb_req_t pic_req;
  wb_pkg::wb_req_t wdt_req;
  wb_pkg::wb_rsp_t ram_rsp;
  wb_pkg::wb_rsp_t disp_rsp;
  wb_pkg::wb_rsp_t pic_rsp;
  wb_pkg::wb_rsp_t wdt_rsp;
  wb_pkg::wb_rsp_t mst_rsp;
  logic            wdt_term;
  logic            tick;

  assign wbm_rsp_o = mst_rsp;
  assign buserr_o  = wdt_term;

  wb_intercon i_intercon (
    .wbm_req_i  (wbm_req_i),
    .wbm_rsp_o  (mst_rsp),
    .wdt_term_i (wdt_term),
    .ram_req_o  (ram_req),
    .disp_req_o (disp_req),
    .pic_req_o  (pic_req),
    .wdt_req_o  (wdt_req),
    .ram_rsp_i  (ram_rsp),
    .disp_rsp_i (disp_rsp),
    .pic_rsp_i  (pic_rsp),
    .wdt_rsp_i  (wdt_rsp)
  );

  ram16_wb i_ram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (ram_req),
    .rsp_o    (ram_rsp)
  );

  hex_display_wb i_disp (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (disp_req),
    .rsp_o    (disp_rsp),
    .hex0_o   (hex0_o),
    .hex1_o   (hex1_o),
    .hex2_o   (hex2_o),
    .hex3_o   (hex3_o)
  );

  mtimer #(
    .TICK_PERIOD (TICK_PERIOD)
  ) i_timer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tick_o   (tick)
  );

  // Timer tick is line 4, buttons fill lines 3..0
  mpic_wb i_pic (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (pic_req),
    .rsp_o    (pic_rsp),
    .irq_i    ({tick, btn_i}),
    .irq_o    (irq_o)
  );

  // Watches the master strobe against the combined ack
  wb_watchdog i_watchdog (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .mstb_i   (wbm_req_i.stb),
    .mack_i   (mst_rsp.ack),
    .req_i    (wdt_req),
    .rsp_o    (wdt_rsp),
    .term_o   (wdt_term)
  );

endmodule

/* tests/marin_periph_tb.sv */
// Directed testbench for the peripheral subsystem that acts as the bus master.
// Runs with TICK_PERIOD 20 so the timer test stays short.
// Outputs are sampled on the falling clock edge.
`include "marin_params.svh"

module marin_periph_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TB_TICK     = 20;
  localparam int ACK_TIMEOUT = 2 * `MARIN_WDT_LIMIT + 8;
  // Sum of the test lengths with margin
  localparam int MAX_CYCLES  = 2000;

  localparam wb_pkg::wb_addr_t DISP_ADR = `MARIN_DISP_BASE;
  localparam wb_pkg::wb_addr_t PIC_ADR  = `MARIN_PIC_BASE;
  localparam wb_pkg::wb_addr_t WDT_ADR  = `MARIN_WDT_BASE;

  logic              clk = 1'b0;
  logic              arst_n;
  wb_pkg::wb_req_t   req;
  wb_pkg::wb_rsp_t   rsp;
  logic [3:0]        btn;
  logic              irq;
  logic              buserr;
  periph_pkg::seg7_t hex0;
  periph_pkg::seg7_t hex1;
  periph_pkg::seg7_t hex2;
  periph_pkg::seg7_t hex3;
  integer            seed;
  int                errors;
  int                checks;

  always #5 clk = ~clk;

  marin_periph #(
    .TICK_PERIOD (TB_TICK)
  ) i_marin_periph (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .wbm_req_i (req),
    .wbm_rsp_o (rsp),
    .btn_i     (btn),
    .irq_o     (irq),
    .buserr_o  (buserr),
    .hex0_o    (hex0),
    .hex1_o    (hex1),
    .hex2_o    (hex2),
    .hex3_o    (hex3)
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Standard digit shapes as lit segments and then inverted for active-low pins
  function automatic periph_pkg::seg7_t seg_for(input periph_pkg::hex_digit_t d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // One bus cycle with the strobe held until ack and dropped on the next edge
  task automatic run_cycle(input wb_pkg::wb_addr_t adr, input wb_pkg::wb_data_t dat,
                           input wb_pkg::wb_sel_t sel, input logic we,
                           output wb_pkg::wb_data_t rdat, output logic err);
    int waited;
    waited = 0;
    rdat   = '0;
    err    = 1'b0;
    @(posedge clk);
    req.adr <= adr;
    req.dat <= dat;
    req.sel <= sel;
    req.we  <= we;
    req.stb <= 1'b1;
    @(negedge clk);
    while (!rsp.ack && waited < ACK_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (rsp.ack) begin
      rdat = rsp.dat;
      err  = buserr;
    end else begin
      errors++;
      $display("Bus access to address %h was never acknowledged", adr);
    end
    @(posedge clk);
    req.stb <= 1'b0;
  endtask

  task automatic bus_write(input wb_pkg::wb_addr_t adr, input wb_pkg::wb_data_t dat,
                           input wb_pkg::wb_sel_t sel);
    wb_pkg::wb_data_t rdat;
    logic             err;
    run_cycle(adr, dat, sel, 1'b1, rdat, err);
    check("bus error on write", 32'(err), 32'd0);
  endtask

  task automatic bus_read(input wb_pkg::wb_addr_t adr, output wb_pkg::wb_data_t rdat,
                          output logic err);
    run_cycle(adr, 16'h0000, 2'b11, 1'b0, rdat, err);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check("irq after reset", 32'(irq), 32'd0);
    check("buserr after reset", 32'(buserr), 32'd0);
    check("hex0 after reset", 32'(hex0), 32'h7F);
    check("hex1 after reset", 32'(hex1), 32'h7F);
    check("hex2 after reset", 32'(hex2), 32'h7F);
    check("hex3 after reset", 32'(hex3), 32'h7F);
  endtask

  task automatic test_ram();
    wb_pkg::wb_addr_t adr [6];
    wb_pkg::wb_data_t val [6];
    wb_pkg::wb_data_t rdat;
    logic             err;
    // Distinct word indices from one 64-word block each
    for (int i = 0; i < 6; i++) begin
      adr[i] = 32'((i * 64 + ($random(seed) & 63)) * 2);
      val[i] = 16'($random(seed));
      bus_write(adr[i], val[i], 2'b11);
    end
    for (int i = 0; i < 6; i++) begin
      bus_read(adr[i], rdat, err);
      check("ram readback", 32'(rdat), 32'(val[i]));
      check("ram read error", 32'(err), 32'd0);
    end
    bus_write(32'h0000_03F0, 16'hA5C3, 2'b11);
    bus_write(32'h0000_03F0, 16'h125A, 2'b01);
    bus_read(32'h0000_03F0, rdat, err);
    check("ram low lane write", 32'(rdat), 32'hA55A);
    bus_write(32'h0000_03F0, 16'h7E34, 2'b10);
    bus_read(32'h0000_03F0, rdat, err);
    check("ram high lane write", 32'(rdat), 32'h7E5A);
  endtask

  task automatic test_display();
    wb_pkg::wb_data_t v;
    wb_pkg::wb_data_t rdat;
    logic             err;
    v = 16'($random(seed));
    bus_write(DISP_ADR, v, 2'b11);
    @(negedge clk);
    check("hex0 pattern", 32'(hex0), 32'(seg_for(v[3:0])));
    check("hex1 pattern", 32'(hex1), 32'(seg_for(v[7:4])));
    check("hex2 pattern", 32'(hex2), 32'(seg_for(v[11:8])));
    check("hex3 pattern", 32'(hex3), 32'(seg_for(v[15:12])));
    bus_read(DISP_ADR, rdat, err);
    check("display readback", 32'(rdat), 32'(v));
  endtask

  task automatic test_buttons();
    wb_pkg::wb_data_t rdat;
    logic             err;
    bus_write(PIC_ADR, 16'h001F, 2'b11);
    @(posedge clk);
    btn <= 4'b0100;
    @(posedge clk);
    btn <= 4'b0000;
    bus_read(PIC_ADR, rdat, err);
    check("button pending bits", 32'(rdat[3:0]), 32'h4);
    @(negedge clk);
    check("irq while masked", 32'(irq), 32'd0);
    bus_write(PIC_ADR + 32'd2, 16'h0004, 2'b11);
    @(negedge clk);
    check("irq when enabled", 32'(irq), 32'd1);
    bus_write(PIC_ADR, 16'h0004, 2'b11);
    @(negedge clk);
    check("irq after clear", 32'(irq), 32'd0);
    bus_read(PIC_ADR, rdat, err);
    check("button pending after clear", 32'(rdat[2]), 32'd0);
  endtask

  task automatic test_timer();
    wb_pkg::wb_data_t rdat;
    logic             err;
    int               waited;
    bus_write(PIC_ADR + 32'd2, 16'h0010, 2'b11);
    bus_write(PIC_ADR, 16'h0010, 2'b11);
    waited = 0;
    @(negedge clk);
    while (!irq && waited < 25) begin
      waited++;
      @(negedge clk);
    end
    check("irq from timer tick", 32'(irq), 32'd1);
    bus_read(PIC_ADR, rdat, err);
    check("tick pending bit", 32'(rdat[4]), 32'd1);
    bus_write(PIC_ADR + 32'd2, 16'h0000, 2'b11);
  endtask

  task automatic test_unmapped();
    wb_pkg::wb_data_t rdat;
    logic             err;
    bus_read(32'h8000_0000, rdat, err);
    check("buserr on unmapped read", 32'(err), 32'd1);
    check("data on unmapped read", 32'(rdat), 32'd0);
    bus_read(WDT_ADR, rdat, err);
    check("watchdog status", 32'(rdat), 32'h8001);
    bus_write(WDT_ADR, 16'hFFFF, 2'b11);
    bus_read(WDT_ADR, rdat, err);
    check("watchdog status after clear", 32'(rdat), 32'd0);
  endtask

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Simulation stopped after %0d cycles without finishing", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    seed   = 32'h7d12f419;
    errors = 0;
    checks = 0;
    arst_n <= 1'b1;
    req    <= '0;
    btn    <= '0;
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    test_ram();
    test_display();
    test_buttons();
    test_timer();
    test_unmapped();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
logic/wb_pkg.sv
logic/periph_pkg.sv
logic/wb_intercon.sv
logic/wb_watchdog.sv
logic/mtimer.sv
logic/mpic_wb.sv
logic/ram16_wb.sv
logic/hex_display_wb.sv
logic/marin_periph.sv
tests/marin_periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exit status is nonzero when the build or the run fails or the log reports failure.

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vmarin_periph_tb

rm -f "$LOG"

verilator --binary --timing -j 0 -f sim.f --top-module marin_periph_tb \
  && ./"$BIN" | tee "$LOG" \
  && ! grep -q "Test failed" "$LOG" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass, see $LOG"; exit 1; }
